// File: rtl/gtp_ctrl_defs.svh
`ifndef GTP_CTRL_DEFS_SVH
`define GTP_CTRL_DEFS_SVH

// gtp bus widths
`define GTP_ADR_W 14
`define GTP_DAT_W 32
`define GTP_SEL_W 4

// two transceiver lanes share one common block
`define NUM_LANE 2

// transceiver DRP port widths
`define DRP_ADR_W 10
`define DRP_DAT_W 16

// per-lane loopback mode field
`define LOOPBACK_W 3

// upper half of the address space goes to the DRP ports
`define DRP_WINDOW_BIT 13

// lane select inside the DRP window
`define DRP_LANE_BIT 12

// lane select for the local status and control words
`define REG_LANE_BIT 2

`endif

// File: rtl/gtp_ctrl_pkg.sv
`include "gtp_ctrl_defs.svh"

package gtp_ctrl_pkg;

    // bus fields
    typedef logic [`GTP_ADR_W-1:0] gtp_adr_t;
    typedef logic [`GTP_DAT_W-1:0] gtp_dat_t;
    typedef logic [`GTP_SEL_W-1:0] gtp_sel_t;

    // DRP fields
    typedef logic [`DRP_ADR_W-1:0] drp_adr_t;
    typedef logic [`DRP_DAT_W-1:0] drp_dat_t;

    typedef logic [`LOOPBACK_W-1:0] loopback_t;

    // one bit is enough for two lanes
    typedef logic lane_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        gtp_sel_t sel;
        gtp_adr_t adr;
        gtp_dat_t dat;
    } gtp_req_t;

    typedef struct packed {
        logic     ack;
        gtp_dat_t dat;
    } gtp_rsp_t;

    // one accepted bus request, already split by window
    typedef struct packed {
        logic     valid;
        logic     is_drp;
        logic     is_write;
        lane_t    lane;
        gtp_sel_t sel;
        drp_adr_t drp_adr;
        gtp_dat_t wdata;
    } gtp_cmd_t;

    typedef struct packed {
        logic      eye_rst;
        loopback_t loopback;
    } lane_ctrl_t;

    typedef struct packed {
        logic     block_lock;
        logic     high_ber;
        drp_dat_t dmonitor;
    } lane_status_t;

    // en is per lane, the rest is shared by both DRP ports
    typedef struct packed {
        logic [`NUM_LANE-1:0] en;
        logic                 we;
        drp_adr_t             addr;
        drp_dat_t             di;
    } drp_req_t;

    typedef struct packed {
        logic [`NUM_LANE-1:0]     rdy;
        drp_dat_t [`NUM_LANE-1:0] dout;
    } drp_rsp_t;

    typedef enum logic {
        DRP_IDLE,
        DRP_WAIT
    } drp_state_t;

endpackage

// File: rtl/gtp_bus_decode.sv
`include "gtp_ctrl_defs.svh"

module gtp_bus_decode (
    input  logic                   wb_clk_i,
    input  logic                   reset_i,
    input  gtp_ctrl_pkg::gtp_req_t req_i,
    input  logic                   ack_i,
    output gtp_ctrl_pkg::gtp_cmd_t cmd_o
);
    import gtp_ctrl_pkg::*;

    logic     busy_q;
    logic     valid_q;
    logic     req_edge;

    // command fields, only meaningful while valid_q is high
    logic     is_drp_q;
    logic     is_write_q;
    lane_t    lane_q;
    gtp_sel_t sel_q;
    drp_adr_t drp_adr_q;
    gtp_dat_t wdata_q;

    // master holds cyc/stb until ack, so only the first cycle counts
    assign req_edge = req_i.cyc & req_i.stb & ~busy_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_edge;
            if (req_edge) begin
                busy_q <= 1'b1;
            end else if (ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (req_edge) begin
            is_drp_q   <= req_i.adr[`DRP_WINDOW_BIT];
            is_write_q <= req_i.we;
            sel_q      <= req_i.sel;
            wdata_q    <= req_i.dat;
            // DRP word address sits above the byte offset
            drp_adr_q  <= req_i.adr[2 +: `DRP_ADR_W];
            // lane select bit depends on which half is addressed
            if (req_i.adr[`DRP_WINDOW_BIT]) begin
                lane_q <= req_i.adr[`DRP_LANE_BIT];
            end else begin
                lane_q <= req_i.adr[`REG_LANE_BIT];
            end
        end
    end

    assign cmd_o = '{
        valid:    valid_q,
        is_drp:   is_drp_q,
        is_write: is_write_q,
        lane:     lane_q,
        sel:      sel_q,
        drp_adr:  drp_adr_q,
        wdata:    wdata_q
    };

endmodule

// File: rtl/gbe_ctrl_regs.sv
`include "gtp_ctrl_defs.svh"

module gbe_ctrl_regs (
    input  logic                                     wb_clk_i,
    input  logic                                     reset_i,
    input  gtp_ctrl_pkg::gtp_cmd_t                   cmd_i,
    output logic                                     gbe_rst_o,
    output gtp_ctrl_pkg::lane_ctrl_t [`NUM_LANE-1:0] lane_ctrl_o
);
    import gtp_ctrl_pkg::*;

    logic                       gbe_rst_q;
    lane_ctrl_t [`NUM_LANE-1:0] lane_ctrl_q;
    logic                       local_wr;

    // DRP commands never touch the local registers
    assign local_wr = cmd_i.valid & ~cmd_i.is_drp & cmd_i.is_write;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            gbe_rst_q   <= 1'b0;
            lane_ctrl_q <= '0;
        end else if (local_wr) begin
            // byte 0 holds the resets
            if (cmd_i.sel[0]) begin
                gbe_rst_q                       <= cmd_i.wdata[0];
                lane_ctrl_q[cmd_i.lane].eye_rst <= cmd_i.wdata[4];
            end
            // byte 1 holds the loopback mode
            if (cmd_i.sel[1]) begin
                lane_ctrl_q[cmd_i.lane].loopback <= cmd_i.wdata[8 +: `LOOPBACK_W];
            end
        end
    end

    // shared transceiver reset goes to both lanes and the common block
    assign gbe_rst_o   = gbe_rst_q;
    assign lane_ctrl_o = lane_ctrl_q;

endmodule

// File: rtl/drp_bridge.sv
`include "gtp_ctrl_defs.svh"

module drp_bridge (
    input  logic                   wb_clk_i,
    input  logic                   reset_i,
    input  gtp_ctrl_pkg::gtp_cmd_t cmd_i,
    output gtp_ctrl_pkg::drp_req_t drp_o,
    input  gtp_ctrl_pkg::drp_rsp_t drp_i,
    output logic                   done_o,
    output gtp_ctrl_pkg::drp_dat_t rdata_o
);
    import gtp_ctrl_pkg::*;

    drp_state_t           state_q;
    logic [`NUM_LANE-1:0] en_q;
    logic                 we_q;
    logic                 done_q;
    drp_adr_t             addr_q;
    drp_dat_t             di_q;
    drp_dat_t             rdata_q;
    lane_t                lane_q;
    logic                 drp_start;

    assign drp_start = cmd_i.valid & cmd_i.is_drp;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= DRP_IDLE;
            en_q    <= '0;
            we_q    <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            // en and done are single cycle strobes
            en_q   <= '0;
            done_q <= 1'b0;
            case (state_q)
                DRP_IDLE: begin
                    if (drp_start) begin
                        en_q[cmd_i.lane] <= 1'b1;
                        we_q             <= cmd_i.is_write;
                        state_q          <= DRP_WAIT;
                    end
                end
                DRP_WAIT: begin
                    // the other lane's rdy is ignored here
                    if (drp_i.rdy[lane_q]) begin
                        we_q    <= 1'b0;
                        done_q  <= 1'b1;
                        state_q <= DRP_IDLE;
                    end
                end
                default: begin
                    state_q <= DRP_IDLE;
                end
            endcase
        end
    end

    // address, write data and lane stay put for the whole access
    always_ff @(posedge wb_clk_i) begin
        if (state_q == DRP_IDLE && drp_start) begin
            addr_q <= cmd_i.drp_adr;
            di_q   <= cmd_i.wdata[`DRP_DAT_W-1:0];
            lane_q <= cmd_i.lane;
        end
        if (state_q == DRP_WAIT && drp_i.rdy[lane_q]) begin
            rdata_q <= drp_i.dout[lane_q];
        end
    end

    assign drp_o = '{
        en:   en_q,
        we:   we_q,
        addr: addr_q,
        di:   di_q
    };

    assign done_o  = done_q;
    assign rdata_o = rdata_q;

endmodule

// File: rtl/gtp_status_result.sv
`include "gtp_ctrl_defs.svh"

module gtp_status_result (
    input  logic                                       wb_clk_i,
    input  logic                                       reset_i,
    input  gtp_ctrl_pkg::gtp_cmd_t                     cmd_i,
    input  logic                                       gbe_rst_i,
    input  gtp_ctrl_pkg::lane_ctrl_t [`NUM_LANE-1:0]   lane_ctrl_i,
    input  logic                                       qpll_lock_i,
    input  gtp_ctrl_pkg::lane_status_t [`NUM_LANE-1:0] lane_status_i,
    input  logic                                       drp_done_i,
    input  gtp_ctrl_pkg::drp_dat_t                     drp_rdata_i,
    output gtp_ctrl_pkg::gtp_rsp_t                     rsp_o
);
    import gtp_ctrl_pkg::*;

    logic     local_ack_q;
    logic     drp_pend_q;
    gtp_dat_t local_dat_q;
    gtp_dat_t status_word;
    logic     local_cmd;

    assign local_cmd = cmd_i.valid & ~cmd_i.is_drp;

    // status word of the lane picked by the command
    always_comb begin
        lane_ctrl_t   sel_ctrl;
        lane_status_t sel_stat;
        sel_ctrl                       = lane_ctrl_i[cmd_i.lane];
        sel_stat                       = lane_status_i[cmd_i.lane];
        status_word                    = '0;
        status_word[0]                 = gbe_rst_i;
        status_word[1]                 = qpll_lock_i;
        status_word[2]                 = sel_stat.block_lock;
        status_word[3]                 = sel_stat.high_ber;
        status_word[4]                 = sel_ctrl.eye_rst;
        status_word[8 +: `LOOPBACK_W]  = sel_ctrl.loopback;
        status_word[16 +: `DRP_DAT_W]  = sel_stat.dmonitor;
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            local_ack_q <= 1'b0;
            drp_pend_q  <= 1'b0;
        end else begin
            local_ack_q <= local_cmd;
            if (cmd_i.valid && cmd_i.is_drp) begin
                drp_pend_q <= 1'b1;
            end else if (drp_done_i) begin
                drp_pend_q <= 1'b0;
            end
        end
    end

    // writes echo their data, reads return the status word
    always_ff @(posedge wb_clk_i) begin
        if (local_cmd) begin
            local_dat_q <= cmd_i.is_write ? cmd_i.wdata : status_word;
        end
    end

    // DRP ack follows done directly, zero extended read data
    assign rsp_o.ack = local_ack_q | (drp_pend_q & drp_done_i);
    assign rsp_o.dat = drp_pend_q ? gtp_dat_t'(drp_rdata_i) : local_dat_q;

endmodule

// File: rtl/gtp_ctrl_top.sv
`include "gtp_ctrl_defs.svh"

module gtp_ctrl_top (
    input  logic                                       wb_clk_i,
    input  logic                                       reset_i,
    input  gtp_ctrl_pkg::gtp_req_t                     req_i,
    output gtp_ctrl_pkg::gtp_rsp_t                     rsp_o,
    input  logic                                       qpll_lock_i,
    input  gtp_ctrl_pkg::lane_status_t [`NUM_LANE-1:0] lane_status_i,
    output logic                                       gbe_rst_o,
    output gtp_ctrl_pkg::lane_ctrl_t [`NUM_LANE-1:0]   lane_ctrl_o,
    output gtp_ctrl_pkg::drp_req_t                     drp_o,
    input  gtp_ctrl_pkg::drp_rsp_t                     drp_i
);
    import gtp_ctrl_pkg::*;

    gtp_cmd_t cmd;
    logic     drp_done;
    drp_dat_t drp_rdata;

    // ack from the result stage releases the decoder
    gtp_bus_decode u_decode (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .ack_i    (rsp_o.ack),
        .cmd_o    (cmd)
    );

    gbe_ctrl_regs u_regs (
        .wb_clk_i    (wb_clk_i),
        .reset_i     (reset_i),
        .cmd_i       (cmd),
        .gbe_rst_o   (gbe_rst_o),
        .lane_ctrl_o (lane_ctrl_o)
    );

    // runs the upper half of the address space on the DRP ports
    drp_bridge u_drp (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .cmd_i    (cmd),
        .drp_o    (drp_o),
        .drp_i    (drp_i),
        .done_o   (drp_done),
        .rdata_o  (drp_rdata)
    );

    // control outputs are read back into the status word
    gtp_status_result u_result (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .cmd_i         (cmd),
        .gbe_rst_i     (gbe_rst_o),
        .lane_ctrl_i   (lane_ctrl_o),
        .qpll_lock_i   (qpll_lock_i),
        .lane_status_i (lane_status_i),
        .drp_done_i    (drp_done),
        .drp_rdata_i   (drp_rdata),
        .rsp_o         (rsp_o)
    );

endmodule

// File: verification/drp_lane_model.sv
`include "gtp_ctrl_defs.svh"

module drp_lane_model (
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    input  gtp_ctrl_pkg::drp_req_t       drp_i,
    input  logic [2:0]                   delay_i,
    output gtp_ctrl_pkg::drp_rsp_t       drp_o,
    output logic [`NUM_LANE-1:0][15:0]   en_count_o
);
    import gtp_ctrl_pkg::*;

    drp_dat_t                 mem [`NUM_LANE][1 << `DRP_ADR_W];
    logic [`NUM_LANE-1:0]     rdy_q;
    drp_dat_t [`NUM_LANE-1:0] dout_q;
    logic [2:0]               wait_q [`NUM_LANE];
    logic                     we_q [`NUM_LANE];
    drp_adr_t                 addr_q [`NUM_LANE];
    drp_dat_t                 di_q [`NUM_LANE];

    always @(posedge wb_clk_i) begin
        for (int l = 0; l < `NUM_LANE; l++) begin
            rdy_q[l] <= 1'b0;
            if (reset_i) begin
                wait_q[l]     <= 3'd0;
                en_count_o[l] <= 16'd0;
                // each word carries its lane and address
                for (int a = 0; a < (1 << `DRP_ADR_W); a++) begin
                    mem[l][a] <= {l[0], 5'h0b, drp_adr_t'(a)};
                end
            end else if (drp_i.en[l]) begin
                en_count_o[l] <= en_count_o[l] + 16'd1;
                wait_q[l]     <= delay_i;
                we_q[l]       <= drp_i.we;
                addr_q[l]     <= drp_i.addr;
                di_q[l]       <= drp_i.di;
            end else if (wait_q[l] != 3'd0) begin
                wait_q[l] <= wait_q[l] - 3'd1;
                // access completes together with rdy
                if (wait_q[l] == 3'd1) begin
                    rdy_q[l] <= 1'b1;
                    if (we_q[l]) begin
                        mem[l][addr_q[l]] <= di_q[l];
                    end else begin
                        dout_q[l] <= mem[l][addr_q[l]];
                    end
                end
            end
        end
    end

    assign drp_o = '{rdy: rdy_q, dout: dout_q};

endmodule

// File: verification/tb_gtp_ctrl.sv
`include "gtp_ctrl_defs.svh"

module tb_gtp_ctrl;
    import gtp_ctrl_pkg::*;

    localparam int ACK_TIMEOUT = 50;

    logic                           wb_clk_i = 1'b0;
    logic                           reset_i = 1'b1;
    gtp_req_t                       req;
    gtp_rsp_t                       rsp;
    logic                           qpll_lock;
    lane_status_t [`NUM_LANE-1:0]   lane_status;
    logic                           gbe_rst;
    lane_ctrl_t [`NUM_LANE-1:0]     lane_ctrl;
    drp_req_t                       drp_req;
    drp_rsp_t                       drp_rsp;
    logic [2:0]                     rdy_delay;
    logic [`NUM_LANE-1:0][15:0]     en_count;
    integer                         seed;

    // reference state
    logic                           ref_gbe_rst;
    logic                           ref_eye [`NUM_LANE];
    loopback_t                      ref_lb [`NUM_LANE];
    drp_dat_t                       ref_mem [`NUM_LANE][1 << `DRP_ADR_W];

    // expected DRP request of the access in flight
    lane_t                          exp_lane;
    drp_adr_t                       exp_addr;
    logic                           exp_we;
    drp_dat_t                       exp_di;

    gtp_ctrl_top i_dut (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .req_i         (req),
        .rsp_o         (rsp),
        .qpll_lock_i   (qpll_lock),
        .lane_status_i (lane_status),
        .gbe_rst_o     (gbe_rst),
        .lane_ctrl_o   (lane_ctrl),
        .drp_o         (drp_req),
        .drp_i         (drp_rsp)
    );

    drp_lane_model i_lanes (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .drp_i      (drp_req),
        .delay_i    (rdy_delay),
        .drp_o      (drp_rsp),
        .en_count_o (en_count)
    );

    always #5 wb_clk_i = ~wb_clk_i;

    task automatic report_error(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input gtp_dat_t got, input gtp_dat_t exp, input string what);
        assert (got == exp)
        else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    // en strobes only one lane for one cycle
    a_en_one_lane: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        !(drp_req.en[0] && drp_req.en[1]))
        else report_error("DRP en high on both lanes");
    a_en_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        |drp_req.en |=> drp_req.en == '0)
        else report_error("DRP en longer than one cycle");
    a_drp_ack: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        |drp_rsp.rdy |=> rsp.ack)
        else report_error("no ack one cycle after DRP rdy");
    a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
        rsp.ack |=> !rsp.ack)
        else report_error("ack longer than one cycle");

    always @(posedge wb_clk_i) begin
        if (!reset_i && |drp_req.en) begin
            assert (drp_req.en[exp_lane] && drp_req.addr == exp_addr && drp_req.we == exp_we
                    && (!exp_we || drp_req.di == exp_di))
            else report_error("DRP request does not match the bus access");
        end
    end

    // one Wishbone cycle with the latency counted from the request edge
    task automatic bus_access(input logic we, input gtp_sel_t sel, input gtp_adr_t adr,
                              input gtp_dat_t wdat, output gtp_dat_t rdat, output int lat);
        int cycles;
        @(posedge wb_clk_i);
        req <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
        cycles = 0;
        do begin
            @(posedge wb_clk_i);
            cycles++;
            if (cycles >= ACK_TIMEOUT) begin
                $display("no ack within %0d cycles for address %h at time %0t",
                         ACK_TIMEOUT, adr, $time);
                $display("FAIL: see errors above");
                $fatal(1, "bus access timed out");
            end
        end while (!rsp.ack);
        rdat = rsp.dat;
        lat  = cycles - 1;
        req <= '0;
    endtask

    function automatic gtp_adr_t local_adr(input lane_t lane);
        return {1'b0, 10'($random(seed)), lane, 2'b00};
    endfunction

    function automatic gtp_dat_t expected_status(input lane_t lane);
        gtp_dat_t w;
        w          = '0;
        w[0]       = ref_gbe_rst;
        w[1]       = qpll_lock;
        w[2]       = lane_status[lane].block_lock;
        w[3]       = lane_status[lane].high_ber;
        w[4]       = ref_eye[lane];
        w[10:8]    = ref_lb[lane];
        w[31:16]   = lane_status[lane].dmonitor;
        return w;
    endfunction

    task automatic check_controls();
        check_value(gtp_dat_t'({gbe_rst, lane_ctrl}),
                    gtp_dat_t'({ref_gbe_rst, ref_eye[1], ref_lb[1], ref_eye[0], ref_lb[0]}),
                    "control outputs");
    endtask

    task automatic local_read(input lane_t lane);
        gtp_dat_t rdat;
        int       lat;
        bus_access(1'b0, 4'hf, local_adr(lane), '0, rdat, lat);
        assert (lat == 2)
        else report_error($sformatf("local read ack after %0d cycles", lat));
        check_value(rdat, expected_status(lane), "status word");
    endtask

    task automatic local_write(input lane_t lane, input gtp_sel_t sel, input gtp_dat_t data);
        gtp_dat_t rdat;
        int       lat;
        bus_access(1'b1, sel, local_adr(lane), data, rdat, lat);
        if (sel[0]) begin
            ref_gbe_rst   = data[0];
            ref_eye[lane] = data[4];
        end
        if (sel[1]) begin
            ref_lb[lane] = data[10:8];
        end
        assert (lat == 2)
        else report_error($sformatf("local write ack after %0d cycles", lat));
        check_value(rdat, data, "local write data on ack");
        check_controls();
    endtask

    task automatic drp_access(input logic we, input lane_t lane, input drp_adr_t addr,
                              input drp_dat_t wdat);
        logic [`NUM_LANE-1:0][15:0] count_before;
        gtp_dat_t                   rdat;
        int                         lat;
        count_before = en_count;
        exp_lane     = lane;
        exp_addr     = addr;
        exp_we       = we;
        exp_di       = wdat;
        rdy_delay   <= 3'(1 + ($unsigned($random(seed)) % 6));
        bus_access(we, 4'hf, {1'b1, lane, addr, 2'($random(seed))},
                   {16'($random(seed)), wdat}, rdat, lat);
        for (int l = 0; l < `NUM_LANE; l++) begin
            check_value(gtp_dat_t'(en_count[l] - count_before[l]),
                        (l == int'(lane)) ? 32'd1 : 32'd0, "DRP en pulses per lane");
        end
        if (we) begin
            ref_mem[lane][addr] = wdat;
        end else begin
            check_value(rdat, gtp_dat_t'(ref_mem[lane][addr]), "DRP read data");
        end
    endtask

    task automatic randomize_status();
        @(posedge wb_clk_i);
        qpll_lock <= 1'($random(seed));
        for (int l = 0; l < `NUM_LANE; l++) begin
            lane_status[l] <= lane_status_t'($random(seed));
        end
    endtask

    initial begin
        lane_t    lane;
        drp_adr_t addr;
        seed        = 32'h8ee437e7;
        req         = '0;
        qpll_lock   = 1'b0;
        lane_status = '0;
        rdy_delay   = 3'd1;
        ref_gbe_rst = 1'b0;
        for (int l = 0; l < `NUM_LANE; l++) begin
            ref_eye[l] = 1'b0;
            ref_lb[l]  = '0;
            for (int a = 0; a < (1 << `DRP_ADR_W); a++) begin
                ref_mem[l][a] = {l[0], 5'h0b, drp_adr_t'(a)};
            end
        end
        repeat (3) @(posedge wb_clk_i);
        reset_i <= 1'b0;

        // state right after reset
        @(posedge wb_clk_i);
        check_controls();
        check_value(gtp_dat_t'({rsp.ack, drp_req.en, drp_req.we}), '0, "ack and DRP strobes");
        local_read(1'b0);
        local_read(1'b1);

        // status inputs land in the status word
        repeat (8) begin
            randomize_status();
            local_read(1'b0);
            local_read(1'b1);
        end

        // every byte enable combination on both lanes
        for (int s = 0; s < 16; s++) begin
            for (int l = 0; l < `NUM_LANE; l++) begin
                local_write(lane_t'(l), gtp_sel_t'(s), gtp_dat_t'($random(seed)));
                local_read(1'b0);
                local_read(1'b1);
            end
        end

        // DRP writes, read back and a look at the other lane
        repeat (12) begin
            lane = lane_t'($random(seed));
            addr = drp_adr_t'($random(seed));
            drp_access(1'b1, lane, addr, drp_dat_t'($random(seed)));
            drp_access(1'b0, lane, addr, '0);
            drp_access(1'b0, ~lane, addr, '0);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/gtp_ctrl_pkg.sv
rtl/gtp_bus_decode.sv
rtl/gbe_ctrl_regs.sv
rtl/drp_bridge.sv
rtl/gtp_status_result.sv
rtl/gtp_ctrl_top.sv
verification/drp_lane_model.sv
verification/tb_gtp_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_gtp_ctrl
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
